// ==== csr_index_config_config.svh ====
`ifndef CSR_INDEX_CONFIG_CONFIG_SVH
`define CSR_INDEX_CONFIG_CONFIG_SVH

// ----------------------------------------------------------
// Response word geometry
// ----------------------------------------------------------
`define CFG_DATA_W      32
`define CFG_ADDR_W      32
`define CFG_SHIFT_W     5

// ----------------------------------------------------------
// Configuration window
// ----------------------------------------------------------
// Words per engine window, and bits to index one of them
`define CFG_SEQ_WIDTH   16
`define CFG_SEQ_INDEX_W 4

`define CFG_FIFO_DEPTH  32
`define CFG_POINTER_W   64

`endif

// ==== csr_index_config_pkg.sv ====
`include "csr_index_config_config.svh"

package csr_index_config_pkg;

    // ----------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------
    typedef logic [`CFG_DATA_W-1:0]      data_word_t;
    typedef logic [`CFG_ADDR_W-1:0]      offset_t;
    typedef logic [`CFG_SHIFT_W-1:0]     shift_t;
    typedef logic [`CFG_SEQ_INDEX_W-1:0] seq_index_t;
    typedef logic [`CFG_SEQ_WIDTH-1:0]   seq_mask_t;

    // Bit 0 increment, 1 decrement, 2 mode_sequence, 3 mode_buffer
    typedef logic [3:0] control_flags_t;

    // Top bit of the granularity word is the shift direction
    typedef logic [`CFG_DATA_W-2:0]      granularity_t;
    typedef logic [`CFG_POINTER_W-1:0]   array_pointer_t;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        struct_invalid      = 3'd0,
        struct_cu_setup     = 3'd1,
        struct_engine_setup = 3'd2,
        struct_data         = 3'd3
    } buffer_class_e;

    typedef enum logic [1:0] {
        cmd_invalid = 2'd0,
        cmd_read    = 2'd1,
        cmd_write   = 2'd2,
        cmd_flush   = 2'd3
    } memory_cmd_e;

    // Assembler FSM
    typedef enum logic [1:0] {
        collecting = 2'd0,
        presenting = 2'd1
    } assembler_state_e;

endpackage

// ==== config_word_if.sv ====
interface config_word_if;
    import csr_index_config_pkg::*;

    // One filtered word, index relative to the engine window
    logic       valid;
    logic       ready;
    seq_index_t index;
    data_word_t data;

    modport source (
        output valid,
        output index,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  index,
        input  data,
        output ready
    );

endinterface

// ==== response_filter.sv ====
`include "csr_index_config_config.svh"

module response_filter #(
    parameter int unsigned id_relative = 0
) (
    input  logic                                ap_clk,
    input  logic                                areset_csr_index_generator,
    input  logic                                response_valid,
    output logic                                response_ready,
    input  csr_index_config_pkg::buffer_class_e response_class,
    input  csr_index_config_pkg::offset_t       response_offset,
    input  csr_index_config_pkg::shift_t        response_shift,
    input  csr_index_config_pkg::data_word_t    response_data,
    config_word_if.source                       words
);
    import csr_index_config_pkg::*;

    // First sequence number owned by this engine
    localparam offset_t seq_min = offset_t'(id_relative * `CFG_SEQ_WIDTH);

    logic          hold_valid;
    buffer_class_e hold_class;
    offset_t       hold_offset;
    shift_t        hold_shift;
    data_word_t    hold_data;
    offset_t       hold_seq;
    offset_t       rel_seq;
    logic          class_ok;
    logic          in_window;
    logic          keep;
    logic          release_hold;
    logic          accept;

    // ----------------------------------------------------------
    // Class and window filter
    // ----------------------------------------------------------
    assign hold_seq = hold_offset >> hold_shift;
    // Wrapping subtract covers both window bounds in one compare
    assign rel_seq  = hold_seq - seq_min;

    assign class_ok  = (hold_class == struct_cu_setup) || (hold_class == struct_engine_setup);
    assign in_window = rel_seq < offset_t'(`CFG_SEQ_WIDTH);
    assign keep      = class_ok && in_window;

    // ----------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------
    // Rejected words drop out without waiting for downstream
    assign release_hold   = hold_valid && (!keep || words.ready);
    assign response_ready = !hold_valid || release_hold;
    assign accept         = response_valid && response_ready;

    assign words.valid = hold_valid && keep;
    assign words.index = rel_seq[`CFG_SEQ_INDEX_W-1:0];
    assign words.data  = hold_data;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (release_hold) begin
            hold_valid <= 1'b0;
        end
    end

    // Holding register payload
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            hold_class  <= response_class;
            hold_offset <= response_offset;
            hold_shift  <= response_shift;
            hold_data   <= response_data;
        end
    end

endmodule

// ==== config_word_fifo.sv ====
`include "csr_index_config_config.svh"

module config_word_fifo (
    input logic           ap_clk,
    input logic           areset_csr_index_generator,
    config_word_if.sink   push,
    config_word_if.source pop
);
    import csr_index_config_pkg::*;

    localparam int depth = `CFG_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    // Storage, split by field
    seq_index_t index_mem [depth];
    data_word_t data_mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    // ----------------------------------------------------------
    // Handshakes
    // ----------------------------------------------------------
    assign push.ready = (count != full_count);
    assign do_push    = push.valid && push.ready;

    // Head word shows on the output without a read request
    assign pop.valid = (count != '0);
    assign pop.index = index_mem[rd_ptr];
    assign pop.data  = data_mem[rd_ptr];
    assign do_pop    = pop.valid && pop.ready;

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            index_mem[wr_ptr] <= push.index;
            data_mem[wr_ptr]  <= push.data;
        end
    end

endmodule

// ==== config_assembler.sv ====
`include "csr_index_config_config.svh"

module config_assembler (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_index_generator,
    config_word_if.sink                          words,
    input  logic                                 config_ready,
    output logic                                 config_valid,
    output csr_index_config_pkg::control_flags_t config_control,
    output csr_index_config_pkg::data_word_t     config_index_start,
    output csr_index_config_pkg::data_word_t     config_index_end,
    output csr_index_config_pkg::data_word_t     config_stride,
    output csr_index_config_pkg::granularity_t   config_granularity,
    output logic                                 config_shift_direction,
    output csr_index_config_pkg::memory_cmd_e    config_cmd,
    output csr_index_config_pkg::buffer_class_e  config_buffer,
    output csr_index_config_pkg::array_pointer_t config_array_pointer,
    output csr_index_config_pkg::data_word_t     config_array_size
);
    import csr_index_config_pkg::*;

    assembler_state_e state;
    seq_mask_t        seen_mask;
    seq_mask_t        seen_next;
    logic             pop;

    // ----------------------------------------------------------
    // Word intake
    // ----------------------------------------------------------
    // No pops while a finished configuration waits
    assign words.ready = (state == collecting);
    assign pop         = words.valid && words.ready;
    assign seen_next   = seen_mask | (seq_mask_t'(1) << words.index);

    assign config_valid = (state == presenting);

    // ----------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state     <= collecting;
            seen_mask <= '0;
        end else begin
            case (state)
                collecting: begin
                    if (pop) begin
                        // Window complete, hand it out and start over
                        if (&seen_next) begin
                            state     <= presenting;
                            seen_mask <= '0;
                        end else begin
                            seen_mask <= seen_next;
                        end
                    end
                end
                presenting: begin
                    if (config_ready) begin
                        state <= collecting;
                    end
                end
                default: begin
                    state <= collecting;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Field decode by window position
    // ----------------------------------------------------------
    // Fields persist across windows, repeats overwrite
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            case (words.index)
                4'd0: begin
                    config_control <= control_flags_t'(words.data[3:0]);
                end
                4'd1: begin
                    config_index_start <= words.data;
                end
                4'd2: begin
                    config_index_end <= words.data;
                end
                4'd3: begin
                    config_stride <= words.data;
                end
                4'd4: begin
                    config_granularity     <= words.data[`CFG_DATA_W-2:0];
                    config_shift_direction <= words.data[`CFG_DATA_W-1];
                end
                4'd5: begin
                    config_cmd    <= memory_cmd_e'(words.data[1:0]);
                    config_buffer <= buffer_class_e'(words.data[4:2]);
                end
                4'd6: begin
                    config_array_pointer[`CFG_DATA_W-1:0] <= words.data;
                end
                4'd7: begin
                    config_array_pointer[`CFG_POINTER_W-1:`CFG_DATA_W] <= words.data;
                end
                4'd8: begin
                    config_array_size <= words.data;
                end
                default: begin
                    // Positions 9 to 15 only count toward the mask
                end
            endcase
        end
    end

endmodule

// ==== csr_index_configure_memory.sv ====
module csr_index_configure_memory #(
    parameter int unsigned id_relative = 0
) (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_index_generator,

    // Memory response stream
    input  logic                                 response_valid,
    output logic                                 response_ready,
    input  csr_index_config_pkg::buffer_class_e  response_class,
    input  csr_index_config_pkg::offset_t        response_offset,
    input  csr_index_config_pkg::shift_t         response_shift,
    input  csr_index_config_pkg::data_word_t     response_data,

    // Assembled configuration
    input  logic                                 config_ready,
    output logic                                 config_valid,
    output csr_index_config_pkg::control_flags_t config_control,
    output csr_index_config_pkg::data_word_t     config_index_start,
    output csr_index_config_pkg::data_word_t     config_index_end,
    output csr_index_config_pkg::data_word_t     config_stride,
    output csr_index_config_pkg::granularity_t   config_granularity,
    output logic                                 config_shift_direction,
    output csr_index_config_pkg::memory_cmd_e    config_cmd,
    output csr_index_config_pkg::buffer_class_e  config_buffer,
    output csr_index_config_pkg::array_pointer_t config_array_pointer,
    output csr_index_config_pkg::data_word_t     config_array_size
);

    // Filter to FIFO, then FIFO to assembler
    config_word_if filtered_words ();
    config_word_if buffered_words ();

    response_filter #(
        .id_relative(id_relative)
    ) u_response_filter (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_ready             (response_ready),
        .response_class             (response_class),
        .response_offset            (response_offset),
        .response_shift             (response_shift),
        .response_data              (response_data),
        .words                      (filtered_words)
    );

    config_word_fifo u_config_word_fifo (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .push                       (filtered_words),
        .pop                        (buffered_words)
    );

    config_assembler u_config_assembler (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .words                      (buffered_words),
        .config_ready               (config_ready),
        .config_valid               (config_valid),
        .config_control             (config_control),
        .config_index_start         (config_index_start),
        .config_index_end           (config_index_end),
        .config_stride              (config_stride),
        .config_granularity         (config_granularity),
        .config_shift_direction     (config_shift_direction),
        .config_cmd                 (config_cmd),
        .config_buffer              (config_buffer),
        .config_array_pointer       (config_array_pointer),
        .config_array_size          (config_array_size)
    );

endmodule

// ==== csr_index_configure_memory_assertions.sv ====
module csr_index_configure_memory_assertions (
    input logic                                 ap_clk,
    input logic                                 areset_csr_index_generator,
    input logic                                 response_ready,
    input logic                                 config_ready,
    input logic                                 config_valid,
    input csr_index_config_pkg::control_flags_t config_control,
    input csr_index_config_pkg::data_word_t     config_index_start,
    input csr_index_config_pkg::data_word_t     config_index_end,
    input csr_index_config_pkg::data_word_t     config_stride,
    input csr_index_config_pkg::granularity_t   config_granularity,
    input logic                                 config_shift_direction,
    input csr_index_config_pkg::memory_cmd_e    config_cmd,
    input csr_index_config_pkg::buffer_class_e  config_buffer,
    input csr_index_config_pkg::array_pointer_t config_array_pointer,
    input csr_index_config_pkg::data_word_t     config_array_size
);

    // Held configuration must not move before the consumer takes it
    property config_held;
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        config_valid && !config_ready |=> config_valid && $stable(config_control) &&
            $stable(config_index_start) && $stable(config_index_end) &&
            $stable(config_stride) && $stable(config_granularity) &&
            $stable(config_shift_direction) && $stable(config_cmd) &&
            $stable(config_buffer) &&
            $stable(config_array_pointer) && $stable(config_array_size);
    endproperty

    assert property (config_held)
        else $error("config output changed while waiting for config_ready");

    // Filter holding register starts empty
    assert property (@(posedge ap_clk)
        $past(areset_csr_index_generator) && !areset_csr_index_generator |-> response_ready)
        else $error("response_ready low in first cycle after reset");

    assert property (@(posedge ap_clk) disable iff (areset_csr_index_generator)
        !$isunknown(config_valid))
        else $error("config_valid unknown");

endmodule

bind csr_index_configure_memory csr_index_configure_memory_assertions u_assertions (.*);

// ==== tb_csr_index_configure_memory.sv ====
`include "csr_index_config_config.svh"

module tb_csr_index_configure_memory;
    import csr_index_config_pkg::*;

    localparam int unsigned id_relative = 1;
    localparam int max_rows = 256;

    typedef struct packed {
        control_flags_t control;
        data_word_t     index_start;
        data_word_t     index_end;
        data_word_t     stride;
        granularity_t   granularity;
        logic           shift_direction;
        memory_cmd_e    cmd;
        buffer_class_e  buffer;
        array_pointer_t array_pointer;
        data_word_t     array_size;
    } expected_cfg_t;

    logic           ap_clk;
    logic           areset_csr_index_generator;
    logic           response_valid;
    logic           response_ready;
    buffer_class_e  response_class;
    offset_t        response_offset;
    shift_t         response_shift;
    data_word_t     response_data;
    logic           config_ready;
    logic           config_valid;
    control_flags_t config_control;
    data_word_t     config_index_start;
    data_word_t     config_index_end;
    data_word_t     config_stride;
    granularity_t   config_granularity;
    logic           config_shift_direction;
    memory_cmd_e    config_cmd;
    buffer_class_e  config_buffer;
    array_pointer_t config_array_pointer;
    data_word_t     config_array_size;

    // Stimulus table: class, offset, shift, data, hold config_ready low
    buffer_class_e  row_class  [max_rows];
    offset_t        row_offset [max_rows];
    shift_t         row_shift  [max_rows];
    data_word_t     row_data   [max_rows];
    logic           row_hold   [max_rows];
    int             row_count;
    int             scenario_end [5];

    integer         seed;
    int             error_count;
    logic           ready_low;
    logic           stall_seen;
    expected_cfg_t  model;
    seq_mask_t      model_mask;
    expected_cfg_t  expected_q [$];

    csr_index_configure_memory #(
        .id_relative(id_relative)
    ) DUT (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .response_valid             (response_valid),
        .response_ready             (response_ready),
        .response_class             (response_class),
        .response_offset            (response_offset),
        .response_shift             (response_shift),
        .response_data              (response_data),
        .config_ready               (config_ready),
        .config_valid               (config_valid),
        .config_control             (config_control),
        .config_index_start         (config_index_start),
        .config_index_end           (config_index_end),
        .config_stride              (config_stride),
        .config_granularity         (config_granularity),
        .config_shift_direction     (config_shift_direction),
        .config_cmd                 (config_cmd),
        .config_buffer              (config_buffer),
        .config_array_pointer       (config_array_pointer),
        .config_array_size          (config_array_size)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------------------------
    task automatic stop_on_error();
        error_count = error_count + 1;
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_flags(input string name, input control_flags_t got,
                               input control_flags_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_granularity(input granularity_t got, input granularity_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: granularity got %h expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_pointer(input array_pointer_t got, input array_pointer_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: array_pointer got %h expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_cmd(input memory_cmd_e got, input memory_cmd_e exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: cmd got %0d expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_class(input buffer_class_e got, input buffer_class_e exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: buffer got %0d expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_outputs(input expected_cfg_t exp);
        check_flags("control", config_control, exp.control);
        check_word("index_start", config_index_start, exp.index_start);
        check_word("index_end", config_index_end, exp.index_end);
        check_word("stride", config_stride, exp.stride);
        check_granularity(config_granularity, exp.granularity);
        check_bit("shift_direction", config_shift_direction, exp.shift_direction);
        check_cmd(config_cmd, exp.cmd);
        check_class(config_buffer, exp.buffer);
        check_pointer(config_array_pointer, exp.array_pointer);
        check_word("array_size", config_array_size, exp.array_size);
    endtask

    // ----------------------------------------------------------
    // Reference model and table construction
    // ----------------------------------------------------------
    task automatic model_apply(input int i);
        logic [31:0] seq;
        int          pos;
        seq = row_offset[i] >> row_shift[i];
        if ((row_class[i] == struct_cu_setup || row_class[i] == struct_engine_setup) &&
            seq >= 32'd16 && seq < 32'd32) begin
            pos = int'(seq) - 16;
            case (pos)
                0: model.control = row_data[i][3:0];
                1: model.index_start = row_data[i];
                2: model.index_end = row_data[i];
                3: model.stride = row_data[i];
                4: begin
                    model.granularity     = row_data[i][30:0];
                    model.shift_direction = row_data[i][31];
                end
                5: begin
                    model.cmd    = memory_cmd_e'(row_data[i][1:0]);
                    model.buffer = buffer_class_e'(row_data[i][4:2]);
                end
                6: model.array_pointer[31:0] = row_data[i];
                7: model.array_pointer[63:32] = row_data[i];
                8: model.array_size = row_data[i];
                default: ;
            endcase
            model_mask[pos] = 1'b1;
            if (&model_mask) begin
                expected_q.push_back(model);
                model_mask = '0;
            end
        end
    endtask

    task automatic add_row(input buffer_class_e c, input offset_t o, input shift_t s,
                           input logic h);
        row_class[row_count]  = c;
        row_offset[row_count] = o;
        row_shift[row_count]  = s;
        row_data[row_count]   = $random(seed);
        row_hold[row_count]   = h;
        row_count = row_count + 1;
    endtask

    // Position p of the window, low offset bits below the shift filled with junk
    function automatic offset_t window_offset(input int p, input shift_t s);
        offset_t o;
        o = offset_t'(16 + p) << s;
        if (s != 0) begin
            o = o | (offset_t'(p) & ((offset_t'(1) << s) - 1));
        end
        return o;
    endfunction

    task automatic add_window(input buffer_class_e c, input shift_t s, input logic h);
        for (int p = 0; p < 16; p++) begin
            add_row(c, window_offset(p, s), s, h);
        end
    endtask

    task automatic build_table();
        row_count = 0;
        add_window(struct_cu_setup, 0, 1'b0);
        scenario_end[0] = row_count - 1;
        // Out of order, position 3 repeated, position 15 last
        add_row(struct_engine_setup, 32'd19, 0, 1'b0);
        for (int p = 14; p >= 0; p--) begin
            if (p != 3) begin
                add_row(struct_cu_setup, offset_t'(16 + p), 0, 1'b0);
            end
        end
        add_row(struct_cu_setup, 32'd19, 0, 1'b0);
        add_row(struct_cu_setup, 32'd31, 0, 1'b0);
        scenario_end[1] = row_count - 1;
        // Foreign classes and neighbouring windows mixed in
        for (int p = 0; p < 16; p++) begin
            if (p == 4 || p == 15) begin
                add_row(struct_data, 32'd18, 0, 1'b0);
                add_row(struct_invalid, 32'd21, 0, 1'b0);
                add_row(struct_cu_setup, 32'd15, 0, 1'b0);
                add_row(struct_engine_setup, 32'd32, 0, 1'b0);
            end
            add_row(struct_engine_setup, offset_t'(16 + p), 0, 1'b0);
        end
        scenario_end[2] = row_count - 1;
        add_row(struct_cu_setup, 32'd68, 2, 1'b0);
        add_window(struct_engine_setup, 2, 1'b0);
        add_window(struct_cu_setup, 3, 1'b0);
        scenario_end[3] = row_count - 1;
        // Enough windows to fill the FIFO and the holding register
        for (int w = 0; w < 4; w++) begin
            add_window(struct_cu_setup, 0, 1'b1);
        end
        scenario_end[4] = row_count - 1;
    endtask

    // ----------------------------------------------------------
    // Driving and waiting
    // ----------------------------------------------------------
    task automatic send_row(input int i);
        int   cycles;
        int   stall;
        logic accepted;
        cycles = 0;
        stall  = 0;
        ready_low       = row_hold[i] && !stall_seen;
        response_valid  = 1'b1;
        response_class  = row_class[i];
        response_offset = row_offset[i];
        response_shift  = row_shift[i];
        response_data   = row_data[i];
        do begin
            @(posedge ap_clk);
            accepted = response_ready;
            cycles   = cycles + 1;
            if (!accepted) begin
                stall = stall + 1;
            end
            if (ready_low && stall >= 20) begin
                stall_seen = 1'b1;
                ready_low  = 1'b0;
            end
            if (!accepted && cycles > 300) begin
                $display("Timeout: response_ready never rose for row %0d", i);
                stop_on_error();
            end
        end while (!accepted);
        model_apply(i);
        #1;
        response_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(posedge ap_clk);
            cycles = cycles + 1;
            if (cycles > 1000) begin
                $display("Timeout: %0d expected configurations never appeared",
                         expected_q.size());
                stop_on_error();
            end
        end
        repeat (20) @(posedge ap_clk);
        #1;
    endtask

    // Random config_ready unless back-pressure is requested
    initial begin
        config_ready = 1'b0;
        forever begin
            @(posedge ap_clk);
            #1;
            config_ready = ready_low ? 1'b0 : (($random(seed) & 3) != 0);
        end
    end

    // ----------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------
    initial begin
        logic          waiting;
        expected_cfg_t snapshot;
        expected_cfg_t head;
        waiting = 1'b0;
        forever begin
            @(posedge ap_clk);
            if (!areset_csr_index_generator) begin
                if (waiting) begin
                    check_bit("config_valid held", config_valid, 1'b1);
                    check_outputs(snapshot);
                end
                if (config_valid && config_ready) begin
                    if (expected_q.size() == 0) begin
                        $display("Unexpected configuration transferred at %0t", $time);
                        stop_on_error();
                    end
                    head = expected_q.pop_front();
                    check_outputs(head);
                end
                waiting = config_valid && !config_ready;
                snapshot = '{config_control, config_index_start, config_index_end,
                             config_stride, config_granularity, config_shift_direction,
                             config_cmd, config_buffer, config_array_pointer,
                             config_array_size};
            end
        end
    end

    initial begin
        int k;
        seed        = 45831;
        error_count = 0;
        ready_low   = 1'b0;
        stall_seen  = 1'b0;
        model       = '0;
        model_mask  = '0;
        k           = 0;
        areset_csr_index_generator = 1'b1;
        response_valid  = 1'b0;
        response_class  = struct_invalid;
        response_offset = '0;
        response_shift  = '0;
        response_data   = '0;
        build_table();
        repeat (8) @(posedge ap_clk);
        #1;
        areset_csr_index_generator = 1'b0;
        for (int i = 0; i < row_count; i++) begin
            send_row(i);
            if (i == scenario_end[k]) begin
                ready_low = 1'b0;
                wait_drain();
                k = k + 1;
            end
        end
        if (!stall_seen) begin
            $display("response_ready never fell while config_ready was held low");
            stop_on_error();
        end
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== csr_index_configure_memory.f ====
+incdir+.
csr_index_config_pkg.sv
config_word_if.sv
response_filter.sv
config_word_fifo.sv
config_assembler.sv
csr_index_configure_memory.sv
csr_index_configure_memory_assertions.sv
tb_csr_index_configure_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_csr_index_configure_memory \
    -f csr_index_configure_memory.f \
    -o sim_tb

# The simulator exits nonzero on failure; the log search decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    exit 1
fi
exit 0
